// File: Makefile
# Verilator build and run of the lifecycle stand-in testbench

BIN := obj_dir/Vlc_bfm_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module lc_bfm_tb \
		-f lc_bfm.f -Mdir obj_dir

# Output goes to the terminal, the grep status is the verdict
run: compile
	./$(BIN) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: dv/lc_bfm_asserts.sv
// Concurrent checks on the top-level ports of the stand-in block.
// Bound into every lc_bfm instance by the bind statement at the end.

module lc_bfm_asserts import lc_bfm_pkg::*; (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  lc_init_i,
    input logic                  fake_reset_i,
    input logic [NUM_ALERTS-1:0] alerts_i,
    input logic                  esc_scrap0_i,
    input logic                  esc_scrap1_i,
    input logic [LC_TX_W-1:0]    clk_byp_ack_i
);

    // lc_init only while out of fake reset
    init_needs_reset_high: assert property (
        @(posedge clk) disable iff (!reset_n) lc_init_i |-> fake_reset_i
    ) else $error("lc_init_o high while fake_reset_o is low");

    // Both scrap levels follow the OR of the alerts
    scrap0_follows_alerts: assert property (
        @(posedge clk) disable iff (!reset_n) esc_scrap0_i == (|alerts_i)
    ) else $error("esc_scrap0_o differs from the OR of the alerts");

    scrap1_follows_alerts: assert property (
        @(posedge clk) disable iff (!reset_n) esc_scrap1_i == (|alerts_i)
    ) else $error("esc_scrap1_o differs from the OR of the alerts");

    // Ack never On in two cycles running
    byp_ack_not_twice: assert property (
        @(posedge clk) disable iff (!reset_n)
        (clk_byp_ack_i == LC_TX_ON) |=> (clk_byp_ack_i != LC_TX_ON)
    ) else $error("clk_byp_ack_o On for two cycles in a row");

endmodule

bind lc_bfm lc_bfm_asserts u_asserts (
    .clk           (clk),
    .reset_n       (reset_n),
    .lc_init_i     (lc_init_o),
    .fake_reset_i  (fake_reset_o),
    .alerts_i      (alerts_i),
    .esc_scrap0_i  (esc_scrap0_o),
    .esc_scrap1_i  (esc_scrap1_o),
    .clk_byp_ack_i (clk_byp_ack_o)
);

// File: dv/lc_bfm_tb.sv
// Randomized testbench for the lifecycle controller stand-in block.
// Drives every input from a seeded generator on the falling edge and checks
// all outputs against a cycle model just after each rising edge.

module lc_bfm_tb import lc_bfm_pkg::*; ();

    localparam int INIT_CYCLES = 40;
    localparam int ECHO_DEPTH  = 6;
    localparam int NUM_CYCLES  = 3000;
    localparam int CLK_PERIOD  = 40;

    logic clk;
    logic reset_n;
    logic ar_valid;
    logic ar_ready;
    logic [BUS_AW-1:0] ar_addr;
    logic pwrgood;
    logic rma_strap;
    logic lc_init;
    logic fake_reset;
    logic otp_valid;
    logic otp_error;
    logic [LC_STATE_W-1:0] otp_state;
    logic [LC_CNT_W-1:0] otp_count;
    logic [LC_TX_W-1:0] otp_secrets;
    logic otp_valid_out;
    logic otp_error_out;
    logic [LC_STATE_W-1:0] otp_state_out;
    logic [LC_CNT_W-1:0] otp_count_out;
    logic [LC_TX_W-1:0] otp_secrets_out;
    logic [LC_TX_W-1:0] test_tokens_valid;
    logic [LC_TX_W-1:0] rma_token_valid;
    logic [TOKEN_W-1:0] test_unlock_token;
    logic [TOKEN_W-1:0] test_exit_token;
    logic [TOKEN_W-1:0] rma_token;
    logic [LC_TX_W-1:0] byp_req;
    logic [LC_TX_W-1:0] byp_ack;
    logic [NUM_ALERTS-1:0] alerts;
    logic scrap0;
    logic scrap1;
    logic [FLASH_REQ_W-1:0] flash_req;
    logic [FLASH_ACK_W-1:0] flash_ack;

    // Model state
    logic m_pulse;
    logic m_strap;
    int m_cnt;
    logic [ECHO_DEPTH-1:0] m_echo;
    logic m_echo_out;
    logic m_init;
    logic m_frst;
    logic [LC_TX_W-1:0] m_ack;

    integer seed;
    int errors;
    int checks;
    int restarts;

    lc_bfm #(
        .INIT_CYCLES (INIT_CYCLES),
        .ECHO_DEPTH  (ECHO_DEPTH)
    ) dut_i (
        .clk (clk), .reset_n (reset_n),
        .ar_valid_i (ar_valid), .ar_ready_i (ar_ready), .ar_addr_i (ar_addr),
        .pwrgood_i (pwrgood), .rma_strap_o (rma_strap),
        .lc_init_o (lc_init), .fake_reset_o (fake_reset),
        .otp_valid_i (otp_valid), .otp_error_i (otp_error),
        .otp_state_i (otp_state), .otp_count_i (otp_count),
        .otp_secrets_valid_i (otp_secrets),
        .otp_valid_o (otp_valid_out), .otp_error_o (otp_error_out),
        .otp_state_o (otp_state_out), .otp_count_o (otp_count_out),
        .otp_secrets_valid_o (otp_secrets_out),
        .otp_test_tokens_valid_o (test_tokens_valid),
        .otp_rma_token_valid_o (rma_token_valid),
        .otp_test_unlock_token_o (test_unlock_token),
        .otp_test_exit_token_o (test_exit_token),
        .otp_rma_token_o (rma_token),
        .clk_byp_req_i (byp_req), .clk_byp_ack_o (byp_ack),
        .alerts_i (alerts), .esc_scrap0_o (scrap0), .esc_scrap1_o (scrap1),
        .flash_rma_req_i (flash_req), .flash_rma_ack_o (flash_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic compare(input logic [127:0] got, input logic [127:0] exp,
                           input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] s;
        r = $random(seed);
        s = $random(seed);
        ar_valid = r[0] | r[1];
        ar_ready = r[2] | r[3];
        // Power-init reads kept rare so the start-up delay can finish
        case (r[7:4])
            4'd0:             ar_addr = PWR_INIT_ADDR;
            4'd1, 4'd2, 4'd3: ar_addr = RMA_STRAP_ADDR;
            default:          ar_addr = $random(seed);
        endcase
        pwrgood = (r[10:8] != 3'd0);
        // Mostly On, some Off, some invalid codes
        case (r[12:11])
            2'd0, 2'd1: byp_req = LC_TX_ON;
            2'd2:       byp_req = LC_TX_OFF;
            default:    byp_req = r[16:13];
        endcase
        alerts      = r[17] ? r[20:18] : '0;
        flash_req   = (r[22:21] == 2'd0) ? FLASH_RMA_MATCH : r[26:23];
        otp_valid   = r[27];
        otp_error   = r[28];
        otp_secrets = s[3:0];
        otp_count   = s[31:16];
        otp_state   = $random(seed);
    endtask

    // Advances the model by one rising edge, next values from old state
    task automatic step_model();
        logic accept;
        logic hit_pwr;
        logic hit_rma;
        logic pulse_old;
        logic echo_end;
        accept    = ar_valid && ar_ready;
        hit_pwr   = accept && (ar_addr == PWR_INIT_ADDR);
        hit_rma   = accept && (ar_addr == RMA_STRAP_ADDR);
        pulse_old = m_pulse;
        // Strap flip blocked while the pulse is high
        if (hit_rma && !pulse_old) begin
            m_strap = !m_strap;
        end
        m_pulse = hit_pwr && !pulse_old;
        if (pwrgood) begin
            echo_end   = m_echo_out;
            m_echo_out = m_echo[ECHO_DEPTH-1];
            m_echo     = {m_echo[ECHO_DEPTH-2:0], pulse_old};
            if (m_cnt < INIT_CYCLES) begin
                m_cnt++;
                m_init = 1'b0;
            end else if (echo_end) begin
                if (m_frst) begin
                    restarts++;
                end
                m_cnt  = 0;
                m_init = 1'b0;
                m_frst = 1'b0;
            end else begin
                m_init = 1'b1;
                m_frst = 1'b1;
            end
        end
        m_ack = ((byp_req == LC_TX_ON) && (m_ack == LC_TX_OFF)) ? LC_TX_ON : LC_TX_OFF;
    endtask

    task automatic check_outputs();
        compare(rma_strap, m_strap, "rma_strap_o");
        compare(lc_init, m_init, "lc_init_o");
        compare(fake_reset, m_frst, "fake_reset_o");
        compare(byp_ack, m_ack, "clk_byp_ack_o");
        // Record passes through untouched
        compare(otp_valid_out, otp_valid, "otp_valid_o");
        compare(otp_error_out, otp_error, "otp_error_o");
        compare(otp_state_out, otp_state, "otp_state_o");
        compare(otp_count_out, otp_count, "otp_count_o");
        compare(otp_secrets_out, otp_secrets, "otp_secrets_valid_o");
        compare(test_tokens_valid, LC_TX_ON, "otp_test_tokens_valid_o");
        compare(rma_token_valid, LC_TX_ON, "otp_rma_token_valid_o");
        compare(test_unlock_token, FIXED_TOKEN, "otp_test_unlock_token_o");
        compare(test_exit_token, FIXED_TOKEN, "otp_test_exit_token_o");
        compare(rma_token, FIXED_TOKEN, "otp_rma_token_o");
        // High whenever any alert is set
        compare(scrap0, alerts != '0, "esc_scrap0_o");
        compare(scrap1, alerts != '0, "esc_scrap1_o");
        // 0x55 only for request value 5
        compare(flash_ack, (flash_req == 4'd5) ? 8'h55 : 8'hAA, "flash_rma_ack_o");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        seed = 95;
        errors = 0;
        checks = 0;
        restarts = 0;
        reset_n = 1'b0;
        ar_valid = 1'b0;
        ar_ready = 1'b0;
        ar_addr = '0;
        pwrgood = 1'b0;
        otp_valid = 1'b0;
        otp_error = 1'b0;
        otp_state = '0;
        otp_count = '0;
        otp_secrets = LC_TX_OFF;
        byp_req = LC_TX_OFF;
        alerts = '0;
        flash_req = '0;
        // Model reset state
        m_pulse = 1'b0;
        m_strap = 1'b0;
        m_cnt = 0;
        m_echo = '0;
        m_echo_out = 1'b0;
        m_init = 1'b0;
        m_frst = 1'b1;
        m_ack = LC_TX_OFF;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_outputs();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_inputs();
            @(posedge clk);
            step_model();
            #1;
            check_outputs();
            @(negedge clk);
        end
        if (restarts == 0) begin
            errors++;
            $display("No fake reset pulse was produced during the run");
        end
        $display("Checks: %0d, errors: %0d, fake reset pulses: %0d", checks, errors, restarts);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog covers the test length plus margin
    initial begin
        #((NUM_CYCLES + 200) * CLK_PERIOD);
        $display("Timeout, the test did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: lc_bfm.f
logic/lc_bfm_pkg.sv
logic/lc_rd_snoop.sv
logic/lc_pwr_seq.sv
logic/lc_otp_shim.sv
logic/lc_side_resp.sv
logic/lc_bfm.sv
dv/lc_bfm_asserts.sv
dv/lc_bfm_tb.sv

// File: logic/lc_bfm.sv
// Top level of the lifecycle controller stand-in block.
// Wires the bus snooper, power sequencer, OTP shim and side responses together.

module lc_bfm import lc_bfm_pkg::*; #(
    parameter int INIT_CYCLES = 500,
    parameter int ECHO_DEPTH  = 20
) (
    input  logic                   clk,
    input  logic                   reset_n,

    // Snooped read-address channel
    input  logic                   ar_valid_i,
    input  logic                   ar_ready_i,
    input  logic [BUS_AW-1:0]      ar_addr_i,

    // Power manager side
    input  logic                   pwrgood_i,
    output logic                   rma_strap_o,
    output logic                   lc_init_o,
    output logic                   fake_reset_o,

    // OTP lifecycle record in
    input  logic                   otp_valid_i,
    input  logic                   otp_error_i,
    input  logic [LC_STATE_W-1:0]  otp_state_i,
    input  logic [LC_CNT_W-1:0]    otp_count_i,
    input  logic [LC_TX_W-1:0]     otp_secrets_valid_i,

    // OTP lifecycle record out
    output logic                   otp_valid_o,
    output logic                   otp_error_o,
    output logic [LC_STATE_W-1:0]  otp_state_o,
    output logic [LC_CNT_W-1:0]    otp_count_o,
    output logic [LC_TX_W-1:0]     otp_secrets_valid_o,
    output logic [LC_TX_W-1:0]     otp_test_tokens_valid_o,
    output logic [LC_TX_W-1:0]     otp_rma_token_valid_o,
    output logic [TOKEN_W-1:0]     otp_test_unlock_token_o,
    output logic [TOKEN_W-1:0]     otp_test_exit_token_o,
    output logic [TOKEN_W-1:0]     otp_rma_token_o,

    // Clock bypass, escalation and flash
    input  logic [LC_TX_W-1:0]     clk_byp_req_i,
    output logic [LC_TX_W-1:0]     clk_byp_ack_o,
    input  logic [NUM_ALERTS-1:0]  alerts_i,
    output logic                   esc_scrap0_o,
    output logic                   esc_scrap1_o,
    input  logic [FLASH_REQ_W-1:0] flash_rma_req_i,
    output logic [FLASH_ACK_W-1:0] flash_rma_ack_o
);

    // Snooper to sequencer pulse
    logic pwr_init_req;

    lc_rd_snoop u_rd_snoop (
        .clk            (clk),
        .reset_n        (reset_n),
        .ar_valid_i     (ar_valid_i),
        .ar_ready_i     (ar_ready_i),
        .ar_addr_i      (ar_addr_i),
        .pwr_init_req_o (pwr_init_req),
        .rma_strap_o    (rma_strap_o)
    );

    lc_pwr_seq #(
        .INIT_CYCLES (INIT_CYCLES),
        .ECHO_DEPTH  (ECHO_DEPTH)
    ) u_pwr_seq (
        .clk            (clk),
        .reset_n        (reset_n),
        .pwrgood_i      (pwrgood_i),
        .pwr_init_req_i (pwr_init_req),
        .lc_init_o      (lc_init_o),
        .fake_reset_o   (fake_reset_o)
    );

    lc_otp_shim u_otp_shim (
        .otp_valid_i             (otp_valid_i),
        .otp_error_i             (otp_error_i),
        .otp_state_i             (otp_state_i),
        .otp_count_i             (otp_count_i),
        .otp_secrets_valid_i     (otp_secrets_valid_i),
        .otp_valid_o             (otp_valid_o),
        .otp_error_o             (otp_error_o),
        .otp_state_o             (otp_state_o),
        .otp_count_o             (otp_count_o),
        .otp_secrets_valid_o     (otp_secrets_valid_o),
        .otp_test_tokens_valid_o (otp_test_tokens_valid_o),
        .otp_rma_token_valid_o   (otp_rma_token_valid_o),
        .otp_test_unlock_token_o (otp_test_unlock_token_o),
        .otp_test_exit_token_o   (otp_test_exit_token_o),
        .otp_rma_token_o         (otp_rma_token_o)
    );

    lc_side_resp u_side_resp (
        .clk             (clk),
        .reset_n         (reset_n),
        .clk_byp_req_i   (clk_byp_req_i),
        .clk_byp_ack_o   (clk_byp_ack_o),
        .alerts_i        (alerts_i),
        .esc_scrap0_o    (esc_scrap0_o),
        .esc_scrap1_o    (esc_scrap1_o),
        .flash_rma_req_i (flash_rma_req_i),
        .flash_rma_ack_o (flash_rma_ack_o)
    );

endmodule

// File: logic/lc_bfm_pkg.sv
// Shared constants for the lifecycle controller stand-in block.
// Imported by the RTL modules and the testbench for widths, codes and addresses.

package lc_bfm_pkg;

    // ------------------------------------------------------------------------
    // System bus snooping
    // ------------------------------------------------------------------------
    localparam int BUS_AW = 32;

    // Read of this address requests a power-init
    localparam logic [BUS_AW-1:0] PWR_INIT_ADDR  = 32'h7000_0044;
    // Read of this address flips the RMA strap
    localparam logic [BUS_AW-1:0] RMA_STRAP_ADDR = 32'h7000_0048;

    // ------------------------------------------------------------------------
    // Lifecycle multi-bit true/false codes
    // ------------------------------------------------------------------------
    localparam int LC_TX_W = 4;

    // Complementary patterns, every other value is invalid
    localparam logic [LC_TX_W-1:0] LC_TX_ON  = 4'b0101;
    localparam logic [LC_TX_W-1:0] LC_TX_OFF = 4'b1010;

    // ------------------------------------------------------------------------
    // OTP lifecycle record
    // ------------------------------------------------------------------------
    localparam int LC_STATE_W = 32;
    localparam int LC_CNT_W   = 16;
    localparam int TOKEN_W    = 128;

    // Same value for test-unlock, test-exit and RMA
    localparam logic [TOKEN_W-1:0] FIXED_TOKEN = 128'h3852_305b_aecf_5ff1_d5c1_d25f_6db9_058d;

    // ------------------------------------------------------------------------
    // Alerts and flash RMA handshake
    // ------------------------------------------------------------------------
    localparam int NUM_ALERTS  = 3;
    localparam int FLASH_REQ_W = 4;
    localparam int FLASH_ACK_W = 8;

    localparam logic [FLASH_REQ_W-1:0] FLASH_RMA_MATCH = 4'h5;
    localparam logic [FLASH_ACK_W-1:0] FLASH_ACK_YES   = 8'h55;
    localparam logic [FLASH_ACK_W-1:0] FLASH_ACK_NO    = 8'hAA;

endpackage

// File: logic/lc_otp_shim.sv
// Combinational shim on the OTP lifecycle record.
// Record fields pass straight through, token fields are forced to fixed values.

module lc_otp_shim import lc_bfm_pkg::*; (
    // Record from OTP
    input  logic                  otp_valid_i,
    input  logic                  otp_error_i,
    input  logic [LC_STATE_W-1:0] otp_state_i,
    input  logic [LC_CNT_W-1:0]   otp_count_i,
    input  logic [LC_TX_W-1:0]    otp_secrets_valid_i,

    // Record toward the lifecycle consumers
    output logic                  otp_valid_o,
    output logic                  otp_error_o,
    output logic [LC_STATE_W-1:0] otp_state_o,
    output logic [LC_CNT_W-1:0]   otp_count_o,
    output logic [LC_TX_W-1:0]    otp_secrets_valid_o,

    // Overridden token fields
    output logic [LC_TX_W-1:0]    otp_test_tokens_valid_o,
    output logic [LC_TX_W-1:0]    otp_rma_token_valid_o,
    output logic [TOKEN_W-1:0]    otp_test_unlock_token_o,
    output logic [TOKEN_W-1:0]    otp_test_exit_token_o,
    output logic [TOKEN_W-1:0]    otp_rma_token_o
);

    // ------------------------------------------------------------------------
    // Pass-through
    // ------------------------------------------------------------------------
    assign otp_valid_o         = otp_valid_i;
    assign otp_error_o         = otp_error_i;
    assign otp_state_o         = otp_state_i;
    assign otp_count_o         = otp_count_i;
    // Secrets flag kept from OTP
    assign otp_secrets_valid_o = otp_secrets_valid_i;

    // ------------------------------------------------------------------------
    // Token overrides
    // ------------------------------------------------------------------------
    // Always report valid tokens
    assign otp_test_tokens_valid_o = LC_TX_ON;
    assign otp_rma_token_valid_o   = LC_TX_ON;

    // One known token for every transition
    assign otp_test_unlock_token_o = FIXED_TOKEN;
    assign otp_test_exit_token_o   = FIXED_TOKEN;
    assign otp_rma_token_o         = FIXED_TOKEN;

endmodule

// File: logic/lc_pwr_seq.sv
// Power-on sequencing toward the power manager.
// Start-up delay before lc_init, plus a delayed echo of power-init requests
// that produces a fake reset pulse and restarts the delay.

module lc_pwr_seq #(
    // Powered cycles before lc_init rises
    parameter int INIT_CYCLES = 500,
    // Length of the request delay line, at least 2
    parameter int ECHO_DEPTH  = 20
) (
    input  logic clk,
    input  logic reset_n,

    // Power-good level, everything freezes while low
    input  logic pwrgood_i,
    // One-cycle power-init request from the bus snooper
    input  logic pwr_init_req_i,

    output logic lc_init_o,
    output logic fake_reset_o
);

    // Counter must reach INIT_CYCLES itself
    localparam int CNT_W = $clog2(INIT_CYCLES + 1);
    localparam logic [CNT_W-1:0] INIT_LAST = CNT_W'(INIT_CYCLES);

    logic [CNT_W-1:0]      init_cnt_q;
    logic                  init_busy;
    logic [ECHO_DEPTH-1:0] echo_q;
    logic                  echo_out_q;
    logic                  lc_init_q;
    logic                  fake_reset_q;

    // Still counting the start-up delay
    assign init_busy = (init_cnt_q < INIT_LAST);

    // ------------------------------------------------------------------------
    // Request delay line
    // ------------------------------------------------------------------------
    // Shifts only on powered cycles, extra output register at the end
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            echo_q     <= '0;
            echo_out_q <= 1'b0;
        end else if (pwrgood_i) begin
            echo_q     <= {echo_q[ECHO_DEPTH-2:0], pwr_init_req_i};
            echo_out_q <= echo_q[ECHO_DEPTH-1];
        end
    end

    // ------------------------------------------------------------------------
    // Start-up counter and outputs
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            init_cnt_q   <= '0;
            lc_init_q    <= 1'b0;
            // Held in reset until the first sequence completes
            fake_reset_q <= 1'b1;
        end else if (pwrgood_i) begin
            if (init_busy) begin
                // Counting, fake reset keeps its level
                init_cnt_q <= init_cnt_q + 1'b1;
                lc_init_q  <= 1'b0;
            end else if (echo_out_q) begin
                // Echoed request, restart the whole sequence
                init_cnt_q   <= '0;
                lc_init_q    <= 1'b0;
                fake_reset_q <= 1'b0;
            end else begin
                // Sequence done
                lc_init_q    <= 1'b1;
                fake_reset_q <= 1'b1;
            end
        end
    end

    // Echoes landing while busy fall through the branch above and are lost

    assign lc_init_o    = lc_init_q;
    assign fake_reset_o = fake_reset_q;

endmodule

// File: logic/lc_rd_snoop.sv
// Watches read-address handshakes on the system bus.
// Turns reads of two magic addresses into a power-init pulse and an RMA strap level.

module lc_rd_snoop import lc_bfm_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,

    // Read-address channel, observed only
    input  logic              ar_valid_i,
    input  logic              ar_ready_i,
    input  logic [BUS_AW-1:0] ar_addr_i,

    // One-cycle request toward the power sequencer
    output logic              pwr_init_req_o,
    // Strap level, flips once per qualifying read
    output logic              rma_strap_o
);

    logic ar_accept;
    logic hit_pwr_init;
    logic hit_rma_strap;
    logic pwr_init_q;
    logic rma_strap_q;

    // Handshake only counts when both sides agree
    assign ar_accept = ar_valid_i && ar_ready_i;

    // Address decode, qualified by the handshake
    assign hit_pwr_init  = ar_accept && (ar_addr_i == PWR_INIT_ADDR);
    assign hit_rma_strap = ar_accept && (ar_addr_i == RMA_STRAP_ADDR);

    // ------------------------------------------------------------------------
    // Power-init pulse
    // ------------------------------------------------------------------------
    // Self-clearing, so back-to-back hits give every other cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pwr_init_q <= 1'b0;
        end else if (hit_pwr_init && !pwr_init_q) begin
            pwr_init_q <= 1'b1;
        end else begin
            pwr_init_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // RMA strap
    // ------------------------------------------------------------------------
    // Toggle blocked while the pulse is high
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rma_strap_q <= 1'b0;
        end else if (hit_rma_strap && !pwr_init_q) begin
            rma_strap_q <= ~rma_strap_q;
        end
    end

    assign pwr_init_req_o = pwr_init_q;
    assign rma_strap_o    = rma_strap_q;

endmodule

// File: logic/lc_side_resp.sv
// Side-band responses of the stand-in block.
// Clock-bypass acknowledge, escalation scrap levels and the flash RMA acknowledge.

module lc_side_resp import lc_bfm_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,

    // Clock manager bypass handshake
    input  logic [LC_TX_W-1:0]     clk_byp_req_i,
    output logic [LC_TX_W-1:0]     clk_byp_ack_o,

    // Alerts in, escalation levels out
    input  logic [NUM_ALERTS-1:0]  alerts_i,
    output logic                   esc_scrap0_o,
    output logic                   esc_scrap1_o,

    // Flash RMA request and acknowledge byte
    input  logic [FLASH_REQ_W-1:0] flash_rma_req_i,
    output logic [FLASH_ACK_W-1:0] flash_rma_ack_o
);

    logic [LC_TX_W-1:0] byp_ack_q;
    logic               any_alert;

    // ------------------------------------------------------------------------
    // Clock-bypass acknowledge
    // ------------------------------------------------------------------------
    // On only after an Off cycle, so a held request alternates
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byp_ack_q <= LC_TX_OFF;
        end else if ((clk_byp_req_i == LC_TX_ON) && (byp_ack_q == LC_TX_OFF)) begin
            byp_ack_q <= LC_TX_ON;
        end else begin
            // Invalid request codes also land here
            byp_ack_q <= LC_TX_OFF;
        end
    end

    assign clk_byp_ack_o = byp_ack_q;

    // ------------------------------------------------------------------------
    // Escalation
    // ------------------------------------------------------------------------
    // Any alert scraps both ways
    assign any_alert    = |alerts_i;
    assign esc_scrap0_o = any_alert;
    assign esc_scrap1_o = any_alert;

    // ------------------------------------------------------------------------
    // Flash RMA acknowledge
    // ------------------------------------------------------------------------
    assign flash_rma_ack_o = (flash_rma_req_i == FLASH_RMA_MATCH) ? FLASH_ACK_YES : FLASH_ACK_NO;

endmodule
